// ==== rv_pkg.sv ====
/*
 * Shared types and constants of the RV32I multi-cycle core.
 * Data and address width is fixed at 32 bits.
 * Only the major opcodes that the decoder handles are listed.
 * Enum encodings are internal and never cross the top-level ports.
 */
`default_nettype none

package rv_pkg;

	// Data and address width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// First fetch address after reset
	localparam word_t reset_pc = 32'h8000_0000;

	// Major opcodes, bits [6:0] of the instruction
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op = 7'b0110011;

	// Sequencer states
	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEM
	} core_state_e;

	// Decoded instruction class
	// NOP also covers everything not decoded
	typedef enum logic [3:0] {
		LUI,
		AUIPC,
		JAL,
		JALR,
		BRANCH,
		LOAD,
		STORE,
		ARITH,
		NOP
	} instr_class_e;

	// ALU operation
	typedef enum logic [2:0] {
		ADD,
		SUB,
		XOR,
		OR,
		AND,
		SLT,
		SLTU,
		PASS_B
	} alu_op_e;

	// Branch comparison
	typedef enum logic [2:0] {
		EQ,
		NE,
		LT,
		GE,
		LTU,
		GEU
	} cmp_op_e;

endpackage

`default_nettype wire

// ==== rv_decode_if.sv ====
/*
 * Decoded instruction fields, decoder to core.
 * No handshake. Fields are valid while the instruction register
 * holds an instruction, from DECODE onward.
 */
`timescale 1ns/1ps
`default_nettype none

interface rv_decode_if import rv_pkg::*; ();

	instr_class_e instr_class;
	alu_op_e alu_op;
	cmp_op_e cmp_op;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t imm;
	// Immediate replaces rs2 data as ALU operand B
	logic imm_is_b;

	// Decoder side
	modport src (
		output instr_class, alu_op, cmp_op, rs1, rs2, rd, imm, imm_is_b
	);

	// Core side
	modport dst (
		input instr_class, alu_op, cmp_op, rs1, rs2, rd, imm, imm_is_b
	);

endinterface

`default_nettype wire

// ==== rv_decode.sv ====
/*
 * Combinational RV32I decoder, zero latency.
 * Handles LUI, AUIPC, JAL, JALR, branches, LW, SW and the
 * register and immediate ALU forms except shifts.
 * All other encodings come out as NOP with rd forced to zero,
 * so they retire without a write.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
	input word_t instr,
	rv_decode_if.src dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Sign-extended immediates for each format
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Register fields sit in the same place for every format
	assign dec.rs1 = instr[19:15];
	assign dec.rs2 = instr[24:20];

	always_comb begin
		dec.instr_class = NOP;
		dec.alu_op = ADD;
		dec.cmp_op = EQ;
		dec.imm = '0;
		dec.imm_is_b = 1'b0;

		case (opcode)
			opc_lui: begin
				dec.instr_class = LUI;
				dec.alu_op = PASS_B;
				dec.imm = imm_u;
				dec.imm_is_b = 1'b1;
			end
			opc_auipc: begin
				dec.instr_class = AUIPC;
				dec.imm = imm_u;
				dec.imm_is_b = 1'b1;
			end
			opc_jal: begin
				dec.instr_class = JAL;
				dec.imm = imm_j;
				dec.imm_is_b = 1'b1;
			end
			opc_jalr: begin
				if (funct3 == 3'b000) begin
					dec.instr_class = JALR;
				end
				dec.imm = imm_i;
				dec.imm_is_b = 1'b1;
			end
			opc_branch: begin
				// Target add in the ALU, condition in the comparator
				dec.instr_class = BRANCH;
				dec.imm = imm_b;
				dec.imm_is_b = 1'b1;
				case (funct3)
					3'b000: dec.cmp_op = EQ;
					3'b001: dec.cmp_op = NE;
					3'b100: dec.cmp_op = LT;
					3'b101: dec.cmp_op = GE;
					3'b110: dec.cmp_op = LTU;
					3'b111: dec.cmp_op = GEU;
					default: dec.instr_class = NOP;
				endcase
			end
			opc_load: begin
				// Word loads only
				if (funct3 == 3'b010) begin
					dec.instr_class = LOAD;
				end
				dec.imm = imm_i;
				dec.imm_is_b = 1'b1;
			end
			opc_store: begin
				if (funct3 == 3'b010) begin
					dec.instr_class = STORE;
				end
				dec.imm = imm_s;
				dec.imm_is_b = 1'b1;
			end
			opc_op_imm, opc_op: begin
				dec.instr_class = ARITH;
				dec.imm = imm_i;
				dec.imm_is_b = (opcode == opc_op_imm);
				case (funct3)
					3'b000: dec.alu_op = (opcode == opc_op && funct7[5]) ? SUB : ADD;
					3'b010: dec.alu_op = SLT;
					3'b011: dec.alu_op = SLTU;
					3'b100: dec.alu_op = XOR;
					3'b110: dec.alu_op = OR;
					3'b111: dec.alu_op = AND;
					// Shifts are not supported
					default: dec.instr_class = NOP;
				endcase
				// Register form needs funct7 zero, SUB aside
				if (opcode == opc_op && funct7 != 7'b0000000 &&
						!(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
					dec.instr_class = NOP;
				end
			end
			default: begin
				dec.instr_class = NOP;
			end
		endcase
	end

	// NOP never writes back
	assign dec.rd = (dec.instr_class == NOP) ? 5'd0 : instr[11:7];

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
/*
 * Combinational ALU and branch comparator.
 * The comparator has its own operands so a branch target add and
 * its condition are evaluated in the same cycle.
 * SLT and SLTU return 0 or 1.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
	input alu_op_e op,
	input word_t a,
	input word_t b,
	input cmp_op_e cmp,
	input word_t cmp_a,
	input word_t cmp_b,
	output word_t result,
	output logic taken
);

	logic lt_signed;
	logic lt_unsigned;
	logic equal;

	// Shared compare terms
	assign lt_signed = $signed(cmp_a) < $signed(cmp_b);
	assign lt_unsigned = cmp_a < cmp_b;
	assign equal = cmp_a == cmp_b;

	always_comb begin
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			XOR: result = a ^ b;
			OR: result = a | b;
			AND: result = a & b;
			// Operand compare, separate from the branch comparator
			SLT: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			SLTU: result = {{(xlen-1){1'b0}}, a < b};
			PASS_B: result = b;
			default: result = a + b;
		endcase
	end

	// Branch condition on the two register values
	always_comb begin
		case (cmp)
			EQ: taken = equal;
			NE: taken = !equal;
			LT: taken = lt_signed;
			GE: taken = !lt_signed;
			LTU: taken = lt_unsigned;
			GEU: taken = !lt_unsigned;
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
/*
 * 31 general registers, x1 to x31, no reset.
 * Two synchronous read ports with one cycle latency, one write port.
 * Reading a register in the cycle it is written gives the old value.
 * x0 always reads zero and ignores writes.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
	input logic clock,
	input reg_idx_t ra_addr,
	output word_t ra_data,
	input reg_idx_t rb_addr,
	output word_t rb_data,
	input reg_idx_t rd_addr,
	input word_t rd_data,
	input logic rd_en
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clock) begin
		if (rd_en && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	// Registered read, old value on a same-cycle write
	always_ff @(posedge clock) begin
		ra_data <= (ra_addr == 5'd0) ? '0 : regs[ra_addr];
		rb_data <= (rb_addr == 5'd0) ? '0 : regs[rb_addr];
	end

	// Write-back source must be resolved whenever a write happens
	a_no_x_write: assert property (
		@(posedge clock) rd_en |-> !$isunknown(rd_data)
	);

endmodule

`default_nettype wire

// ==== rv_dbus.sv ====
/*
 * Data-bus request unit for word loads and stores.
 * start latches address, write data and direction. dvalid rises the
 * next cycle and holds until dready. done pulses in the handshake cycle.
 * start must not be raised while a request is outstanding.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_dbus import rv_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	input logic store,
	input word_t addr,
	input word_t wdata,
	output logic done,
	output word_t daddr,
	output word_t dwdata,
	output logic dwrite,
	output logic dvalid,
	input logic dready
);

	// Request payload, captured once per transfer
	always_ff @(posedge clock) begin
		if (start) begin
			daddr <= addr;
			dwdata <= wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dvalid <= 1'b0;
			dwrite <= 1'b0;
		end else if (start) begin
			dvalid <= 1'b1;
			dwrite <= store;
		end else if (dvalid && dready) begin
			// Drop the request after the handshake cycle
			dvalid <= 1'b0;
		end
	end

	assign done = dvalid && dready;

	// Request stays put while the memory stalls
	a_req_stable: assert property (
		@(posedge clock) disable iff (reset)
		(dvalid && !dready) |=> ($stable(daddr) && $stable(dwdata) && $stable(dwrite))
	);

endmodule

`default_nettype wire

// ==== rv_core.sv ====
/*
 * Multi-cycle RV32I core, one instruction in flight.
 * FETCH, DECODE, EXECUTE, then MEM for LW and SW only.
 * Both buses use valid/ready; the core waits in FETCH or MEM.
 * No CSRs, no exceptions, no shifts, no sub-word memory access.
 * Jump and branch targets have their two low bits cleared.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
	input logic clock,
	input logic reset,
	output word_t iaddr,
	input word_t idata,
	output logic ivalid,
	input logic iready,
	output word_t daddr,
	output word_t dwdata,
	input word_t drdata,
	output logic dwrite,
	output logic dvalid,
	input logic dready
);

	core_state_e state;
	word_t pc;
	word_t pc_plus4;
	word_t pc_next;
	word_t ir;

	word_t ra_data;
	word_t rb_data;
	word_t rd_data;
	logic rd_en;

	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	logic taken;

	logic is_jump;
	logic is_mem;
	logic dbus_done;

	rv_decode_if dec_if ();

	rv_decode u_decode (
		.instr (ir),
		.dec (dec_if.src)
	);

	assign iaddr = pc;
	assign ivalid = (state == FETCH);

	assign pc_plus4 = pc + 32'd4;
	assign is_jump = (dec_if.instr_class == JAL) || (dec_if.instr_class == JALR);
	assign is_mem = (dec_if.instr_class == LOAD) || (dec_if.instr_class == STORE);

	// Sequencer, PC and instruction register
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
			pc <= reset_pc;
		end else begin
			case (state)
				FETCH: begin
					if (iready) begin
						state <= DECODE;
					end
				end
				// Register file read in flight
				DECODE: state <= EXECUTE;
				EXECUTE: begin
					if (is_mem) begin
						state <= MEM;
					end else begin
						pc <= pc_next;
						state <= FETCH;
					end
				end
				MEM: begin
					if (dbus_done) begin
						pc <= pc_plus4;
						state <= FETCH;
					end
				end
				default: state <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			ir <= idata;
		end
	end

	// Operand A is the PC for PC-relative targets
	always_comb begin
		case (dec_if.instr_class)
			AUIPC, JAL, BRANCH: alu_a = pc;
			default: alu_a = ra_data;
		endcase
	end

	assign alu_b = dec_if.imm_is_b ? dec_if.imm : rb_data;

	rv_alu u_alu (
		.op (dec_if.alu_op),
		.a (alu_a),
		.b (alu_b),
		.cmp (dec_if.cmp_op),
		.cmp_a (ra_data),
		.cmp_b (rb_data),
		.result (alu_result),
		.taken (taken)
	);

	// Low target bits ignored
	assign pc_next = (is_jump || (dec_if.instr_class == BRANCH && taken)) ?
		{alu_result[31:2], 2'b00} : pc_plus4;

	// Write-back source
	always_comb begin
		if (dec_if.instr_class == LOAD) begin
			rd_data = drdata;
		end else if (is_jump) begin
			rd_data = pc_plus4;
		end else begin
			rd_data = alu_result;
		end
	end

	// Loads write on the handshake, everything else in EXECUTE
	always_comb begin
		case (dec_if.instr_class)
			LUI, AUIPC, JAL, JALR, ARITH: rd_en = (state == EXECUTE);
			LOAD: rd_en = (state == MEM) && dbus_done;
			default: rd_en = 1'b0;
		endcase
		if (dec_if.rd == 5'd0) begin
			rd_en = 1'b0;
		end
	end

	// Addresses presented from DECODE on, data ready in EXECUTE
	rv_regfile u_regfile (
		.clock (clock),
		.ra_addr (dec_if.rs1),
		.ra_data (ra_data),
		.rb_addr (dec_if.rs2),
		.rb_data (rb_data),
		.rd_addr (dec_if.rd),
		.rd_data (rd_data),
		.rd_en (rd_en)
	);

	rv_dbus u_dbus (
		.clock (clock),
		.reset (reset),
		.start ((state == EXECUTE) && is_mem),
		.store (dec_if.instr_class == STORE),
		.addr (alu_result),
		.wdata (rb_data),
		.done (dbus_done),
		.daddr (daddr),
		.dwdata (dwdata),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.dready (dready)
	);

	// Fetch and data access never overlap
	a_one_bus: assert property (
		@(posedge clock) disable iff (reset) !(ivalid && dvalid)
	);

	a_state_known: assert property (
		@(posedge clock) disable iff (reset) !$isunknown(state)
	);

endmodule

`default_nettype wire

// ==== tb_mem.sv ====
/*
 * Memory model for both core buses, 256 words each.
 * Addresses wrap inside each array, so only the low word index counts.
 * Ready delays are fixed or random in 0..max_delay, seeded once.
 * Data writes are logged except the end marker store, which sets marker_seen.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem import rv_pkg::*; #(
	parameter word_t prog_base = 32'h8000_0000,
	parameter word_t data_base = 32'h0001_0000,
	parameter int seed_init = 51147
) (
	input logic clock,
	input logic reset,
	input word_t iaddr,
	input logic ivalid,
	output word_t idata,
	output logic iready,
	input word_t daddr,
	input word_t dwdata,
	input logic dwrite,
	input logic dvalid,
	output word_t drdata,
	output logic dready
);

	localparam word_t marker_addr = data_base + 32'h3FC;

	word_t imem [0:255];
	word_t dmem [0:255];
	word_t fetches [$];
	word_t wr_addr [$];
	word_t wr_data [$];
	logic marker_seen;
	logic random_mode;
	int fixed_idelay;
	int fixed_ddelay;
	int max_delay;
	int seed;
	int iwait;
	int dwait;
	logic rst_s;
	logic i_hs;
	logic d_hs;

	function automatic word_t fill_value(word_t addr);
		return addr ^ 32'h5A5A_5A5A;
	endfunction

	function automatic int word_index(word_t addr, word_t base);
		return int'(((addr - base) >> 2) & 32'hFF);
	endfunction

	function int pick_delay(int fixed);
		if (random_mode) begin
			return int'($unsigned($random(seed)) % (max_delay + 1));
		end
		return fixed;
	endfunction

	// Instruction memory back to NOPs, data memory to its fill pattern
	task clear_all();
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000_0013;
			dmem[i] = fill_value(data_base + 4 * i);
		end
		fetches.delete();
		wr_addr.delete();
		wr_data.delete();
		marker_seen = 1'b0;
	endtask

	task set_delays(logic rnd, int idly, int ddly, int maxd);
		random_mode = rnd;
		fixed_idelay = idly;
		fixed_ddelay = ddly;
		max_delay = maxd;
	endtask

	initial begin
		seed = seed_init;
		random_mode = 1'b0;
		fixed_idelay = 0;
		fixed_ddelay = 0;
		max_delay = 0;
		iwait = 0;
		dwait = 0;
		iready = 1'b0;
		dready = 1'b0;
		idata = '0;
		drdata = '0;
		marker_seen = 1'b0;
	end

	always @(posedge clock) begin
		// Handshakes as the DUT sees them at this edge
		rst_s = reset;
		i_hs = ivalid && iready;
		d_hs = dvalid && dready;
		if (!rst_s && i_hs) begin
			fetches.push_back(iaddr);
		end
		if (!rst_s && d_hs && dwrite) begin
			if (daddr == marker_addr) begin
				marker_seen = 1'b1;
			end else begin
				wr_addr.push_back(daddr);
				wr_data.push_back(dwdata);
				dmem[word_index(daddr, data_base)] = dwdata;
			end
		end
		#5;
		// Ready goes high after the chosen number of waiting cycles
		if (rst_s || i_hs || !ivalid) begin
			iready = 1'b0;
			iwait = pick_delay(fixed_idelay);
		end else if (iwait == 0) begin
			iready = 1'b1;
		end else begin
			iwait--;
		end
		if (rst_s || d_hs || !dvalid) begin
			dready = 1'b0;
			dwait = pick_delay(fixed_ddelay);
		end else if (dwait == 0) begin
			dready = 1'b1;
		end else begin
			dwait--;
		end
		idata = imem[word_index(iaddr, prog_base)];
		drdata = dmem[word_index(daddr, data_base)];
	end

endmodule

`default_nettype wire

// ==== tb_core.sv ====
/*
 * Directed tests for the RV32I core.
 * Each test loads a hand-assembled program, resets the core and
 * runs until the end marker store to data_base + 0x3FC.
 * x31 holds data_base in every program and is not used otherwise.
 * Stores are checked in order against the expected address and data.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_core import rv_pkg::*; ;

	localparam word_t prog_base = reset_pc;
	localparam word_t data_base = 32'h0001_0000;
	localparam int seed = 51147;
	localparam int cycles_per_word = 20;
	localparam int max_delay = 3;

	// RV32I major opcodes
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;

	logic clock;
	logic reset;
	word_t iaddr;
	word_t idata;
	logic ivalid;
	logic iready;
	word_t daddr;
	word_t dwdata;
	word_t drdata;
	logic dwrite;
	logic dvalid;
	logic dready;

	string test_name;
	int check_errors;
	int errors_at_start;
	int tests_run;
	int tests_failed;
	int budget_words;
	int prog_len;
	word_t exp_addr [$];
	word_t exp_data [$];

	rv_core rv_core_i (
		.clock (clock),
		.reset (reset),
		.iaddr (iaddr),
		.idata (idata),
		.ivalid (ivalid),
		.iready (iready),
		.daddr (daddr),
		.dwdata (dwdata),
		.drdata (drdata),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.dready (dready)
	);

	tb_mem #(
		.prog_base (prog_base),
		.data_base (data_base),
		.seed_init (seed)
	) mem_i (
		.clock (clock),
		.reset (reset),
		.iaddr (iaddr),
		.ivalid (ivalid),
		.idata (idata),
		.iready (iready),
		.daddr (daddr),
		.dwdata (dwdata),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.drdata (drdata),
		.dready (dready)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Instruction encoders
	function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
			reg_idx_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	// Reference results from the RV32I rules
	function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task check_word(string what, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("** Error [%s] %s: expected %h, actual %h", test_name, what,
				expected, actual);
			check_errors++;
		end
	endtask

	task check_addr(string what, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("** Error [%s] %s: expected address %h, actual address %h",
				test_name, what, expected, actual);
			check_errors++;
		end
	endtask

	task emit(word_t instr);
		mem_i.imem[prog_len] = instr;
		prog_len++;
	endtask

	task load_const(reg_idx_t rd, word_t value);
		word_t hi;
		hi = (value + 32'h800) >> 12;
		emit({hi[19:0], rd, op_lui});
		emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
	endtask

	// SW rs, off(x31) and remember the write it must produce
	task store_at(reg_idx_t rs, logic [11:0] off, word_t value);
		emit({off[11:5], rs, 5'd31, 3'b010, off[4:0], op_store});
		exp_addr.push_back(data_base + off);
		exp_data.push_back(value);
	endtask

	task start_test(string name);
		test_name = name;
		errors_at_start = check_errors;
		// Core held in reset while the program is replaced
		@(posedge clock);
		#5 reset = 1'b1;
		@(posedge clock);
		#5;
		mem_i.clear_all();
		exp_addr.delete();
		exp_data.delete();
		prog_len = 0;
		emit({data_base[31:12], 5'd31, op_lui});
	endtask

	task release_reset();
		// End marker, then spin in place
		emit({7'h1F, 5'd0, 5'd31, 3'b010, 5'h1C, op_store});
		emit(j_type(21'd0, 5'd0));
		budget_words += prog_len;
		@(posedge clock);
		#5 reset = 1'b0;
	endtask

	task wait_marker();
		while (!mem_i.marker_seen) begin
			@(posedge clock);
		end
	endtask

	task check_writes();
		int n;
		n = exp_addr.size();
		if (mem_i.wr_addr.size() != n) begin
			$display("Test %s: expected %0d data writes but the core made %0d",
				test_name, n, mem_i.wr_addr.size());
			check_errors++;
			if (mem_i.wr_addr.size() < n) begin
				n = mem_i.wr_addr.size();
			end
		end
		for (int i = 0; i < n; i++) begin
			check_addr($sformatf("store %0d address", i), exp_addr[i], mem_i.wr_addr[i]);
			check_word($sformatf("store %0d data", i), exp_data[i], mem_i.wr_data[i]);
		end
	endtask

	task check_next_fetch(word_t from, word_t target);
		int idx;
		idx = -1;
		for (int i = 0; i < mem_i.fetches.size(); i++) begin
			if (idx < 0 && mem_i.fetches[i] == from) begin
				idx = i;
			end
		end
		if (idx < 0 || idx + 1 >= mem_i.fetches.size()) begin
			$display("Test %s: no fetch seen after the jump at %h", test_name, from);
			check_errors++;
		end else begin
			check_addr("fetch after jump", target, mem_i.fetches[idx + 1]);
		end
	endtask

	task end_test();
		tests_run++;
		if (check_errors != errors_at_start) begin
			tests_failed++;
		end
		$display("Test %s finished with %0d failed checks", test_name,
			check_errors - errors_at_start);
	endtask

	task reset_test();
		start_test("reset");
		mem_i.set_delays(1'b0, 2, 0, 0);
		release_reset();
		@(negedge clock);
		check_addr("first fetch address", reset_pc, iaddr);
		if (ivalid !== 1'b1) begin
			$display("Test %s: ivalid is not high in the first cycle after reset", test_name);
			check_errors++;
		end
		// No data request before the first instruction arrives
		while (mem_i.fetches.size() == 0) begin
			if (dvalid !== 1'b0) begin
				$display("Test %s: dvalid went high before the first fetch", test_name);
				check_errors++;
			end
			@(negedge clock);
		end
		check_addr("first fetch handshake", reset_pc, mem_i.fetches[0]);
		wait_marker();
		end_test();
	endtask

	task arith_test();
		logic [2:0] r_f3 [7];
		logic r_sub [7];
		logic [2:0] i_f3 [6];
		logic [11:0] imms [2];
		word_t a;
		word_t b;
		logic [11:0] off;
		start_test("arithmetic");
		mem_i.set_delays(1'b0, 1, 0, 0);
		r_f3 = '{3'b000, 3'b000, 3'b100, 3'b110, 3'b111, 3'b010, 3'b011};
		r_sub = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		i_f3 = '{3'b000, 3'b100, 3'b110, 3'b111, 3'b010, 3'b011};
		imms = '{12'hFFB, 12'h123};
		off = 12'd0;
		for (int p = 0; p < 2; p++) begin
			// Operands swapped on the second pass
			a = p ? 32'h0000_5678 : 32'h8000_1234;
			b = p ? 32'h8000_1234 : 32'h0000_5678;
			load_const(1, a);
			load_const(2, b);
			for (int k = 0; k < 7; k++) begin
				emit(r_type(r_sub[k] ? 7'h20 : 7'h00, 2, 1, r_f3[k], 3));
				store_at(3, off, alu_ref(r_f3[k], r_sub[k], a, b));
				off += 12'd4;
			end
			for (int m = 0; m < 2; m++) begin
				for (int k = 0; k < 6; k++) begin
					emit(i_type(imms[m], 1, i_f3[k], 3, op_imm));
					store_at(3, off, alu_ref(i_f3[k], 1'b0, a, {{20{imms[m][11]}}, imms[m]}));
					off += 12'd4;
				end
			end
		end
		release_reset();
		wait_marker();
		check_writes();
		end_test();
	endtask

	task branch_test();
		logic [2:0] b_f3 [6];
		reg_idx_t rs1 [3];
		reg_idx_t rs2 [3];
		word_t va [3];
		word_t vb [3];
		logic [11:0] off;
		start_test("branches");
		mem_i.set_delays(1'b0, 0, 1, 0);
		b_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		rs1 = '{5'd1, 5'd2, 5'd2};
		rs2 = '{5'd2, 5'd3, 5'd4};
		va = '{32'hFFFF_FFFD, 32'd5, 32'd5};
		vb = '{32'd5, 32'd5, 32'hFFFF_FFFD};
		load_const(1, 32'hFFFF_FFFD);
		load_const(2, 32'd5);
		load_const(3, 32'd5);
		load_const(4, 32'hFFFF_FFFD);
		off = 12'd0;
		for (int k = 0; k < 6; k++) begin
			for (int p = 0; p < 3; p++) begin
				// x5 ends as 2 when taken, 1 when not
				emit(i_type(12'd2, 0, 3'b000, 5, op_imm));
				emit(b_type(13'd8, rs2[p], rs1[p], b_f3[k]));
				emit(i_type(12'd1, 0, 3'b000, 5, op_imm));
				store_at(5, off, branch_ref(b_f3[k], va[p], vb[p]) ? 32'd2 : 32'd1);
				off += 12'd4;
			end
		end
		release_reset();
		wait_marker();
		check_writes();
		end_test();
	endtask

	task jump_test();
		word_t jal_pc;
		word_t jalr_pc;
		word_t auipc_pc;
		int t;
		start_test("jumps and upper immediates");
		mem_i.set_delays(1'b0, 2, 2, 0);
		emit(i_type(12'd5, 0, 3'b000, 7, op_imm));
		jal_pc = prog_base + 4 * prog_len;
		emit(j_type(21'd12, 6));
		emit(i_type(12'd9, 0, 3'b000, 7, op_imm));
		emit(i_type(12'd9, 0, 3'b000, 7, op_imm));
		store_at(6, 12'h000, jal_pc + 4);
		store_at(7, 12'h004, 32'd5);
		// Target sits after load_const, the JALR and two skipped words
		t = prog_len + 5;
		load_const(8, prog_base + 4 * t - 4);
		jalr_pc = prog_base + 4 * prog_len;
		emit(i_type(12'd4, 8, 3'b000, 9, op_jalr));
		emit(i_type(12'd9, 0, 3'b000, 7, op_imm));
		emit(i_type(12'd9, 0, 3'b000, 7, op_imm));
		store_at(9, 12'h008, jalr_pc + 4);
		store_at(7, 12'h00C, 32'd5);
		emit({20'hABCDE, 5'd10, op_lui});
		store_at(10, 12'h010, 32'hABCD_E000);
		auipc_pc = prog_base + 4 * prog_len;
		emit({20'h12345, 5'd11, op_auipc});
		store_at(11, 12'h014, 32'h1234_5000 + auipc_pc);
		release_reset();
		wait_marker();
		check_writes();
		check_next_fetch(jal_pc, jal_pc + 12);
		check_next_fetch(jalr_pc, prog_base + 4 * t);
		end_test();
	endtask

	task mem_test();
		word_t v1;
		word_t v2;
		word_t copied;
		mem_i.set_delays(1'b1, 0, 0, max_delay);
		start_test("loads and stores");
		v1 = 32'h1357_9BDF;
		v2 = 32'hDEAD_BEEF;
		copied = mem_i.fill_value(data_base + 32'h100);
		load_const(1, v1);
		load_const(2, v2);
		store_at(1, 12'h040, v1);
		store_at(2, 12'h044, v2);
		emit(i_type(12'h040, 31, 3'b010, 3, op_load));
		emit(i_type(12'h044, 31, 3'b010, 4, op_load));
		store_at(3, 12'h048, v1);
		store_at(4, 12'h04C, v2);
		// Copy of an untouched word
		emit(i_type(12'h100, 31, 3'b010, 5, op_load));
		store_at(5, 12'h104, copied);
		// x0 stays zero through a load and an add
		emit(i_type(12'h040, 31, 3'b010, 0, op_load));
		emit(i_type(12'd77, 0, 3'b000, 0, op_imm));
		store_at(0, 12'h050, 32'd0);
		emit(i_type(12'h050, 31, 3'b010, 6, op_load));
		store_at(6, 12'h054, 32'd0);
		release_reset();
		wait_marker();
		check_writes();
		check_word("memory at 0x40", v1, mem_i.dmem[32'h40 >> 2]);
		check_word("memory at 0x104", copied, mem_i.dmem[32'h104 >> 2]);
		end_test();
	endtask

	// Limit grows with each loaded program and counts only cycles outside reset
	initial begin
		int active;
		active = 0;
		while (active <= budget_words * cycles_per_word + max_delay) begin
			@(posedge clock);
			if (!reset) begin
				active++;
			end
		end
		$display("Watchdog expired during test %s after %0d cycles", test_name, active);
		$display("Test failures found");
		$finish;
	end

	initial begin
		reset = 1'b1;
		check_errors = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		budget_words = 0;
		prog_len = 0;
		test_name = "setup";
		reset_test();
		arith_test();
		branch_test();
		jump_test();
		mem_test();
		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, check_errors);
		if (check_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
rv_pkg.sv
rv_decode_if.sv
rv_decode.sv
rv_alu.sv
rv_regfile.sv
rv_dbus.sv
rv_core.sv
tb_mem.sv
tb_core.sv
